// File: common/gsm_pkg.sv
package gsm_pkg;

	// --------------------
	// port and cell sizes
	// --------------------
	localparam int N_PORTS = 4; // ingress ports, same count on egress
	typedef logic [$clog2(N_PORTS)-1:0] port_idx_t;

	localparam int DWIDTH = 128; // one cell = 16 bytes
	typedef logic [DWIDTH-1:0] cell_t;

	// --------------------
	// shared buffer addressing
	// --------------------
	// address = {owner port, local index}, 128 cells in total
	localparam int AWIDTH = 7;
	typedef logic [AWIDTH-1:0] cell_addr_t;

	localparam int LWIDTH = 5; // 32 cells per ingress port

	// --------------------
	// header fields
	// --------------------
	localparam int LEN_WIDTH = 3; // packet length in cells, header included
	localparam int MAX_PKT_LEN = 7;
	localparam int LOC_PKT_LEN = 24; // lsb of the length field
	localparam int LOC_DEST_IP = 32; // lsb of the destination address

	// admission fsm of the hardware malloc
	typedef enum logic [1:0] {
		ms_idle,  // waiting for a header
		ms_store, // packet accepted, body cells go to the buffer
		ms_drop   // packet refused, body cells are discarded
	} malloc_state_t;

endpackage

// File: hw/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N_PORTS = 4
) (
	input logic clk_320M,
	input logic i_rst_n,
	input logic [N_PORTS-1:0] i_req,
	output logic [N_PORTS-1:0] o_grant // one-hot, zero when nobody asks
);

	localparam int IW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

	logic [IW-1:0] last_q; // last winner, lowest priority next time
	logic [IW-1:0] gnt_idx; // winner of this cycle

	// search starts just after the last winner and wraps
	always_comb begin
		int idx;
		o_grant = '0;
		gnt_idx = last_q;
		for (int k = 1; k <= N_PORTS; k++) begin
			idx = (int'(last_q) + k) % N_PORTS;
			if (i_req[idx] && o_grant == '0) begin
				o_grant[idx] = 1'b1; // first hit wins
				gnt_idx = IW'(idx);
			end
		end
	end

	// priority only moves when somebody was served
	always_ff @(posedge clk_320M) begin
		if (!i_rst_n) begin
			last_q <= IW'(N_PORTS - 1); // port 0 goes first
		end else if (|i_req) begin
			last_q <= gnt_idx;
		end
	end

endmodule

// File: hw/ptr_fifo.sv
`timescale 1ns/1ps

module ptr_fifo #(
	parameter int DEPTH = 32,
	parameter bit PRELOAD = 1'b0 // start full with 0..DEPTH-1
) (
	input logic clk_320M,
	input logic i_rst_n,
	input logic i_push,
	input gsm_pkg::cell_addr_t i_push_data,
	input logic i_pop,
	output gsm_pkg::cell_addr_t o_pop_data, // head, valid in the pop cycle
	output logic o_empty
);

	localparam int PW = $clog2(DEPTH);

	gsm_pkg::cell_addr_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count; // one extra bit to hold DEPTH

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge clk_320M) begin
		if (!i_rst_n && PRELOAD) begin
			// free list comes up holding every local index
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= gsm_pkg::cell_addr_t'(i);
			end
		end else if (i_push) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	// --------------------
	// pointers
	// --------------------
	always_ff @(posedge clk_320M) begin
		if (!i_rst_n) begin
			wr_ptr <= '0; // full preload wraps back to slot 0
			rd_ptr <= '0;
			count <= PRELOAD ? (PW+1)'(DEPTH) : '0;
		end else begin
			if (i_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PW+1)'(i_push) - (PW+1)'(i_pop);
		end
	end

	assign o_pop_data = mem[rd_ptr]; // no read latency
	assign o_empty = (count == '0);

endmodule

// File: hw/cell_buffer.sv
`timescale 1ns/1ps

module cell_buffer (
	input logic clk_320M,

	// write side, one stage per ingress port
	input logic [gsm_pkg::N_PORTS-1:0] i_wr_grant, // one-hot
	input gsm_pkg::cell_addr_t i_wr_addr [gsm_pkg::N_PORTS],
	input gsm_pkg::cell_t i_wr_data [gsm_pkg::N_PORTS],

	// read side
	input logic i_rd_en,
	input gsm_pkg::cell_addr_t i_rd_addr,
	output gsm_pkg::cell_t o_rd_data // one cycle after i_rd_en
);

	gsm_pkg::cell_t mem [2**gsm_pkg::AWIDTH];

	gsm_pkg::cell_addr_t wr_addr;
	gsm_pkg::cell_t wr_data;
	logic wr_en;

	// and-or mux, grant is one-hot so nothing overlaps
	always_comb begin
		wr_addr = '0;
		wr_data = '0;
		for (int p = 0; p < gsm_pkg::N_PORTS; p++) begin
			wr_addr = wr_addr | ({gsm_pkg::AWIDTH{i_wr_grant[p]}} & i_wr_addr[p]);
			wr_data = wr_data | ({gsm_pkg::DWIDTH{i_wr_grant[p]}} & i_wr_data[p]);
		end
	end

	assign wr_en = |i_wr_grant;

	always_ff @(posedge clk_320M) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		if (i_rd_en) begin
			o_rd_data <= mem[i_rd_addr]; // registered read
		end
	end

endmodule

// File: hw/ingress/hw_malloc.sv
`timescale 1ns/1ps

module hw_malloc #(
	parameter gsm_pkg::port_idx_t OWNER = '0
) (
	input logic clk_320M,
	input logic i_rst_n,

	// ingress port
	input logic i_ingress_valid,
	input logic i_ingress_header,
	input gsm_pkg::cell_t i_ingress_data,

	// from the write arbiter and the egress side
	input logic i_wr_grant,
	input logic i_free, // one of our cells has left the buffer
	input logic [gsm_pkg::LWIDTH-1:0] i_free_idx,

	// write stage
	output logic o_wr_req,
	output gsm_pkg::cell_addr_t o_wr_addr,
	output gsm_pkg::cell_t o_wr_data,
	output gsm_pkg::port_idx_t o_wr_dest,

	output logic o_drop
);

	gsm_pkg::malloc_state_t state;

	logic hdr;
	logic body;
	logic accept;
	logic store;
	logic [gsm_pkg::LEN_WIDTH-1:0] pkt_len; // length field of the header
	gsm_pkg::port_idx_t hdr_dest;
	gsm_pkg::port_idx_t pkt_dest; // held for the body cells
	logic [gsm_pkg::LEN_WIDTH-1:0] cells_left; // body cells still to come
	logic [gsm_pkg::LWIDTH:0] free_cnt; // unreserved cells of our slice

	logic stage_full;
	gsm_pkg::cell_t stage_data;
	gsm_pkg::port_idx_t stage_dest;

	gsm_pkg::cell_addr_t fl_head;
	logic fl_empty;

	// --------------------
	// header decode
	// --------------------
	assign hdr = i_ingress_valid & i_ingress_header;
	assign body = i_ingress_valid & ~i_ingress_header;
	assign pkt_len = i_ingress_data[gsm_pkg::LOC_PKT_LEN +: gsm_pkg::LEN_WIDTH];
	assign hdr_dest = i_ingress_data[gsm_pkg::LOC_DEST_IP +: $bits(gsm_pkg::port_idx_t)];

	// legal length and room for the whole packet, else drop it all
	assign accept = hdr && (pkt_len != '0) && (int'(pkt_len) <= gsm_pkg::MAX_PKT_LEN)
		&& (int'(pkt_len) <= int'(free_cnt));

	assign store = (hdr & accept) | (body & (state == gsm_pkg::ms_store));

	// --------------------
	// admission fsm and accounting
	// --------------------
	always_ff @(posedge clk_320M) begin
		if (!i_rst_n) begin
			state <= gsm_pkg::ms_idle;
			cells_left <= '0;
			free_cnt <= (gsm_pkg::LWIDTH+1)'(1 << gsm_pkg::LWIDTH); // whole slice free
			stage_full <= 1'b0;
			o_drop <= 1'b0;
		end else begin
			o_drop <= hdr & ~accept; // pulse right after the header
			if (hdr) begin
				cells_left <= (pkt_len == '0) ? '0 : pkt_len - 1'b1;
				if (pkt_len <= gsm_pkg::LEN_WIDTH'(1)) begin
					state <= gsm_pkg::ms_idle; // header only packet
				end else if (accept) begin
					state <= gsm_pkg::ms_store;
				end else begin
					state <= gsm_pkg::ms_drop;
				end
			end else if (body && state != gsm_pkg::ms_idle) begin
				cells_left <= cells_left - 1'b1;
				if (cells_left == gsm_pkg::LEN_WIDTH'(1)) begin
					state <= gsm_pkg::ms_idle; // last body cell
				end
			end
			// reserve at accept, give back one per freed pointer
			free_cnt <= free_cnt
				- (accept ? (gsm_pkg::LWIDTH+1)'(pkt_len) : '0)
				+ (gsm_pkg::LWIDTH+1)'(i_free);
			stage_full <= store | (stage_full & ~i_wr_grant);
		end
	end

	// one-cell stage, emptied within 4 cycles by the round robin
	always_ff @(posedge clk_320M) begin
		if (hdr) begin
			pkt_dest <= hdr_dest;
		end
		if (store) begin
			stage_data <= i_ingress_data;
			stage_dest <= hdr ? hdr_dest : pkt_dest;
		end
	end

	// local indices of our slice, popped when the stage is written
	ptr_fifo #(
		.DEPTH(1 << gsm_pkg::LWIDTH),
		.PRELOAD(1'b1)
	) free_list (
		.clk_320M(clk_320M),
		.i_rst_n(i_rst_n),
		.i_push(i_free),
		.i_push_data(gsm_pkg::cell_addr_t'(i_free_idx)),
		.i_pop(i_wr_grant),
		.o_pop_data(fl_head),
		.o_empty(fl_empty)
	);

	assign o_wr_req = stage_full & ~fl_empty;
	assign o_wr_addr = {OWNER, fl_head[gsm_pkg::LWIDTH-1:0]}; // owner in the top bits
	assign o_wr_data = stage_data;
	assign o_wr_dest = stage_dest;

endmodule

// File: hw/egress/egress_sched.sv
`timescale 1ns/1ps

module egress_sched (
	input logic clk_320M,
	input logic i_rst_n,

	// write side snoop
	input logic [gsm_pkg::N_PORTS-1:0] i_wr_grant,
	input gsm_pkg::cell_addr_t i_wr_addr [gsm_pkg::N_PORTS],
	input gsm_pkg::port_idx_t i_wr_dest [gsm_pkg::N_PORTS],

	input logic [gsm_pkg::N_PORTS-1:0] i_egress_rd, // reader level per port

	// buffer read port
	input gsm_pkg::cell_t i_rd_data,
	output logic o_rd_en,
	output gsm_pkg::cell_addr_t o_rd_addr,

	output logic [gsm_pkg::N_PORTS-1:0] o_egress_valid,
	output gsm_pkg::cell_t o_egress_data [gsm_pkg::N_PORTS],

	// pointer return
	output logic [gsm_pkg::N_PORTS-1:0] o_free,
	output logic [gsm_pkg::LWIDTH-1:0] o_free_idx
);

	localparam int OW = gsm_pkg::AWIDTH - gsm_pkg::LWIDTH; // owner bits of an address

	gsm_pkg::cell_addr_t wr_addr;
	gsm_pkg::port_idx_t wr_dest;
	logic [gsm_pkg::N_PORTS-1:0] q_push;
	logic [gsm_pkg::N_PORTS-1:0] q_empty;
	gsm_pkg::cell_addr_t q_head [gsm_pkg::N_PORTS];
	logic [gsm_pkg::N_PORTS-1:0] rd_req;
	logic [gsm_pkg::N_PORTS-1:0] rd_grant;
	logic [gsm_pkg::N_PORTS-1:0] rd_grant_q; // port being read last cycle
	gsm_pkg::cell_addr_t rd_addr_q;

	// granted stage address and destination, plus the read address mux
	always_comb begin
		wr_addr = '0;
		wr_dest = '0;
		o_rd_addr = '0;
		for (int p = 0; p < gsm_pkg::N_PORTS; p++) begin
			if (i_wr_grant[p]) begin
				wr_addr = wr_addr | i_wr_addr[p];
				wr_dest = wr_dest | i_wr_dest[p];
			end
			if (rd_grant[p]) begin
				o_rd_addr = o_rd_addr | q_head[p];
			end
		end
	end

	// --------------------
	// per egress port
	// --------------------
	for (genvar d = 0; d < gsm_pkg::N_PORTS; d++) begin : g_port
		assign q_push[d] = (|i_wr_grant) && (wr_dest == gsm_pkg::port_idx_t'(d));
		assign rd_req[d] = ~q_empty[d] & i_egress_rd[d]; // stalled readers get nothing

		// 128 deep, can hold the whole buffer
		ptr_fifo #(
			.DEPTH(1 << gsm_pkg::AWIDTH),
			.PRELOAD(1'b0)
		) queue (
			.clk_320M(clk_320M),
			.i_rst_n(i_rst_n),
			.i_push(q_push[d]),
			.i_push_data(wr_addr),
			.i_pop(rd_grant[d]),
			.o_pop_data(q_head[d]),
			.o_empty(q_empty[d])
		);

		assign o_egress_data[d] = rd_grant_q[d] ? i_rd_data : '0;
		// owner of the cell just read gets its index back
		assign o_free[d] = (|rd_grant_q)
			&& (rd_addr_q[gsm_pkg::AWIDTH-1 -: OW] == gsm_pkg::port_idx_t'(d));
	end

	rr_arbiter #(
		.N_PORTS(gsm_pkg::N_PORTS)
	) rd_arb (
		.clk_320M(clk_320M),
		.i_rst_n(i_rst_n),
		.i_req(rd_req),
		.o_grant(rd_grant)
	);

	assign o_rd_en = |rd_grant;

	// data comes back one cycle after the read
	always_ff @(posedge clk_320M) begin
		if (!i_rst_n) begin
			rd_grant_q <= '0;
		end else begin
			rd_grant_q <= rd_grant;
		end
	end

	always_ff @(posedge clk_320M) begin
		rd_addr_q <= o_rd_addr;
	end

	assign o_egress_valid = rd_grant_q;
	assign o_free_idx = rd_addr_q[gsm_pkg::LWIDTH-1:0];

endmodule

// File: hw/gsm_tile.sv
`timescale 1ns/1ps

module gsm_tile (
	input logic clk_320M,
	input logic i_rst_n,

	// ingress ports
	input logic [gsm_pkg::N_PORTS-1:0] i_ingress_valid,
	input logic [gsm_pkg::N_PORTS-1:0] i_ingress_header,
	input gsm_pkg::cell_t i_ingress_data [gsm_pkg::N_PORTS],

	// egress ports
	input logic [gsm_pkg::N_PORTS-1:0] i_egress_rd,
	output logic [gsm_pkg::N_PORTS-1:0] o_egress_valid,
	output gsm_pkg::cell_t o_egress_data [gsm_pkg::N_PORTS],

	output logic [gsm_pkg::N_PORTS-1:0] o_drop // one pulse per refused packet
);

	// write side, one stage per ingress port
	logic [gsm_pkg::N_PORTS-1:0] wr_req;
	logic [gsm_pkg::N_PORTS-1:0] wr_grant; // one-hot
	gsm_pkg::cell_addr_t wr_addr [gsm_pkg::N_PORTS];
	gsm_pkg::cell_t wr_data [gsm_pkg::N_PORTS];
	gsm_pkg::port_idx_t wr_dest [gsm_pkg::N_PORTS];

	// pointer return to the owners
	logic [gsm_pkg::N_PORTS-1:0] free;
	logic [gsm_pkg::LWIDTH-1:0] free_idx;

	// buffer read port
	logic rd_en;
	gsm_pkg::cell_addr_t rd_addr;
	gsm_pkg::cell_t rd_data;

	// --------------------
	// ingress admission
	// --------------------
	for (genvar p = 0; p < gsm_pkg::N_PORTS; p++) begin : g_malloc
		hw_malloc #(
			.OWNER(gsm_pkg::port_idx_t'(p)) // slice of the buffer owned by this port
		) malloc (
			.clk_320M(clk_320M),
			.i_rst_n(i_rst_n),
			.i_ingress_valid(i_ingress_valid[p]),
			.i_ingress_header(i_ingress_header[p]),
			.i_ingress_data(i_ingress_data[p]),
			.i_wr_grant(wr_grant[p]),
			.i_free(free[p]),
			.i_free_idx(free_idx),
			.o_wr_req(wr_req[p]),
			.o_wr_addr(wr_addr[p]),
			.o_wr_data(wr_data[p]),
			.o_wr_dest(wr_dest[p]),
			.o_drop(o_drop[p])
		);
	end

	// single write port shared round robin
	rr_arbiter #(
		.N_PORTS(gsm_pkg::N_PORTS)
	) wr_arb (
		.clk_320M(clk_320M),
		.i_rst_n(i_rst_n),
		.i_req(wr_req),
		.o_grant(wr_grant)
	);

	// --------------------
	// shared memory
	// --------------------
	cell_buffer buffer (
		.clk_320M(clk_320M),
		.i_wr_grant(wr_grant),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.i_rd_en(rd_en),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data)
	);

	egress_sched sched (
		.clk_320M(clk_320M),
		.i_rst_n(i_rst_n),
		.i_wr_grant(wr_grant),
		.i_wr_addr(wr_addr),
		.i_wr_dest(wr_dest),
		.i_egress_rd(i_egress_rd),
		.i_rd_data(rd_data),
		.o_rd_en(rd_en),
		.o_rd_addr(rd_addr),
		.o_egress_valid(o_egress_valid),
		.o_egress_data(o_egress_data),
		.o_free(free),
		.o_free_idx(free_idx)
	);

endmodule

// File: verification/gsm_tile_asserts.sv
`timescale 1ns/1ps

module gsm_tile_asserts (
	input logic clk_320M,
	input logic i_rst_n,
	input logic [gsm_pkg::N_PORTS-1:0] i_wr_grant, // internal write grant
	input logic [gsm_pkg::N_PORTS-1:0] i_ingress_valid,
	input logic [gsm_pkg::N_PORTS-1:0] i_ingress_header,
	input logic [gsm_pkg::N_PORTS-1:0] i_egress_rd,
	input logic [gsm_pkg::N_PORTS-1:0] i_egress_valid,
	input logic [gsm_pkg::N_PORTS-1:0] i_drop
);

	// --------------------
	// write side
	// --------------------
	wr_grant_onehot: assert property (@(posedge clk_320M) disable iff (!i_rst_n)
		$onehot0(i_wr_grant))
		else $error("write grant has more than one bit set");

	// --------------------
	// egress side
	// --------------------
	// held reset clears the read pipe
	egress_quiet_in_reset: assert property (@(posedge clk_320M)
		(!i_rst_n && $past(!i_rst_n)) |-> (i_egress_valid == '0))
		else $error("egress valid seen during reset");

	// grant needs the reader level, data follows one cycle later
	egress_after_rd: assert property (@(posedge clk_320M) disable iff (!i_rst_n)
		(i_egress_valid & ~$past(i_egress_rd)) == '0)
		else $error("egress valid on a port whose reader was not ready");

	drop_after_header: assert property (@(posedge clk_320M) disable iff (!i_rst_n)
		(i_drop & ~$past(i_ingress_valid & i_ingress_header)) == '0)
		else $error("drop pulse without a header the cycle before");

endmodule

bind gsm_tile gsm_tile_asserts asserts0 (
	.clk_320M(clk_320M),
	.i_rst_n(i_rst_n),
	.i_wr_grant(wr_grant),
	.i_ingress_valid(i_ingress_valid),
	.i_ingress_header(i_ingress_header),
	.i_egress_rd(i_egress_rd),
	.i_egress_valid(o_egress_valid),
	.i_drop(o_drop)
);

// File: verification/tb_gsm_tile.sv
`timescale 1ns/1ps

module tb_gsm_tile;

	localparam int NP = gsm_pkg::N_PORTS;
	localparam int SLICE = 1 << gsm_pkg::LWIDTH; // cells owned by one ingress port

	logic clk_320M = 1'b0;
	logic rst_n;
	logic [NP-1:0] ingress_valid;
	logic [NP-1:0] ingress_header;
	gsm_pkg::cell_t ingress_data [NP];
	logic [NP-1:0] egress_rd;
	logic [NP-1:0] egress_valid;
	gsm_pkg::cell_t egress_data [NP];
	logic [NP-1:0] drop;

	// scoreboard, one ordered stream per (source, destination) pair
	gsm_pkg::cell_t exp_q [NP*NP][$];
	int reserved [NP]; // cells taken by accepted packets
	int freed [NP]; // cells of that source seen at egress
	int pkt_no [NP];
	int sent; // accepted cells in total
	int received;
	string test_name;

	// packets prepared ahead of a concurrent burst
	int plan_dest [NP][8];
	int plan_len [NP][8];
	logic [31:0] plan_salt [NP][8];

	always #20 clk_320M = ~clk_320M; // 40 ns period

	gsm_tile dut0 (
		.clk_320M(clk_320M),
		.i_rst_n(rst_n),
		.i_ingress_valid(ingress_valid),
		.i_ingress_header(ingress_header),
		.i_ingress_data(ingress_data),
		.i_egress_rd(egress_rd),
		.o_egress_valid(egress_valid),
		.o_egress_data(egress_data),
		.o_drop(drop)
	);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic step_cycles(input int n);
		repeat (n) begin
			@(posedge clk_320M);
			#1; // inputs move just after the edge
		end
	endtask

	// header fields at their plan positions, ids in the low byte lanes
	function automatic gsm_pkg::cell_t make_cell(input int p, input int pkt, input int idx,
		input int dest, input int len, input logic [31:0] salt);
		gsm_pkg::cell_t c;
		c = '0;
		c[7:0] = 8'(idx);
		c[15:8] = 8'(p); // source port
		c[23:16] = 8'(pkt);
		c[gsm_pkg::LOC_PKT_LEN +: gsm_pkg::LEN_WIDTH] = 3'(len);
		c[gsm_pkg::LOC_DEST_IP +: 2] = 2'(dest);
		c[127:96] = salt;
		c[95:64] = salt ^ {4{8'(idx)}}; // payload differs per cell
		return c;
	endfunction

	// --------------------
	// ingress driver
	// --------------------
	task automatic send_packet(input int p, input int dest, input int len,
		input logic [31:0] salt, output bit accepted);
		int ncells;
		int free_now;
		gsm_pkg::cell_t c;
		ncells = (len < 1) ? 1 : len; // a zero length still sends its header
		free_now = SLICE - reserved[p] + freed[p];
		accepted = (len >= 1) && (len <= gsm_pkg::MAX_PKT_LEN) && (len <= free_now);
		if (accepted) begin
			reserved[p] += len;
			sent += len;
		end
		for (int i = 0; i < ncells; i++) begin
			c = make_cell(p, pkt_no[p], i, dest, len, salt);
			if (accepted) begin
				exp_q[p*NP + dest].push_back(c);
			end
			ingress_valid[p] = 1'b1;
			ingress_header[p] = (i == 0);
			ingress_data[p] = c;
			step_cycles(1);
			ingress_valid[p] = 1'b0;
			ingress_header[p] = 1'b0;
			if (i == 0) begin
				assert (drop[p] == !accepted) else
					abort_run($sformatf("error %s: drop on port %0d expected %0d actual %0d",
						test_name, p, !accepted, drop[p]));
			end
			step_cycles(3); // one cell per 4 cycles at most
		end
		pkt_no[p]++;
	endtask

	task automatic send_stream(input int p, input int n);
		bit acc;
		for (int k = 0; k < n; k++) begin
			send_packet(p, plan_dest[p][k], plan_len[p][k], plan_salt[p][k], acc);
		end
	endtask

	task automatic plan_packets(input int n);
		for (int p = 0; p < NP; p++) begin
			for (int k = 0; k < n; k++) begin
				plan_dest[p][k] = int'($urandom % NP);
				plan_len[p][k] = 1 + int'($urandom % gsm_pkg::MAX_PKT_LEN);
				plan_salt[p][k] = $urandom;
			end
		end
	endtask

	// --------------------
	// egress monitor
	// --------------------
	task automatic watch_egress();
		int src;
		int key;
		gsm_pkg::cell_t want;
		forever begin
			@(negedge clk_320M); // outputs settled mid cycle
			for (int d = 0; d < NP; d++) begin
				if (egress_valid[d]) begin
					src = int'(egress_data[d][9:8]);
					key = src * NP + d;
					assert (exp_q[key].size() != 0) else
						abort_run($sformatf("unexpected cell at egress port %0d in %s",
							d, test_name));
					if (exp_q[key].size() != 0) begin
						want = exp_q[key].pop_front();
						assert (egress_data[d] == want) else
							abort_run($sformatf("error %s: port %0d expected %h actual %h",
								test_name, d, want, egress_data[d]));
						freed[src]++; // pointer goes home to the source
						received++;
					end
				end
			end
		end
	endtask

	// waits until only target accepted cells are still inside the tile
	task automatic wait_pending(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (sent - received != target) begin
			step_cycles(1);
			cycles++;
			assert (cycles < limit) else
				abort_run($sformatf("timeout in %s with %0d cells still in the tile",
					test_name, sent - received));
		end
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		bit acc;
		int held;
		void'($urandom(32'h462269a2));
		rst_n = 1'b0;
		ingress_valid = '0;
		ingress_header = '0;
		egress_rd = '0;
		for (int p = 0; p < NP; p++) begin
			ingress_data[p] = '0;
			reserved[p] = 0;
			freed[p] = 0;
			pkt_no[p] = 0;
		end
		sent = 0;
		received = 0;
		test_name = "reset";
		repeat (5) @(posedge clk_320M);
		#1;
		rst_n = 1'b1;
		fork
			watch_egress();
		join_none

		test_name = "single_packet";
		egress_rd = '1;
		send_packet(0, 2, 5, $urandom, acc);
		wait_pending(0, 500);

		test_name = "concurrent_ingress";
		plan_packets(4);
		fork
			send_stream(0, 4);
			send_stream(1, 4);
			send_stream(2, 4);
			send_stream(3, 4);
		join
		wait_pending(0, 2000);

		test_name = "read_stall";
		plan_packets(3);
		for (int p = 0; p < NP; p++) begin
			plan_dest[p][0] = 1; // every source feeds the stalled port
		end
		egress_rd[1] = 1'b0;
		fork
			send_stream(0, 3);
			send_stream(1, 3);
			send_stream(2, 3);
			send_stream(3, 3);
		join
		held = 0;
		for (int s = 0; s < NP; s++) begin
			held += exp_q[s*NP + 1].size();
		end
		wait_pending(held, 2000); // others drain past the stall
		egress_rd[1] = 1'b1;
		wait_pending(0, 2000);

		test_name = "drop_on_full";
		egress_rd = '0;
		for (int k = 0; k < 4; k++) begin
			send_packet(3, 0, 7, $urandom, acc); // 28 of 32 cells reserved
		end
		send_packet(3, 0, 7, $urandom, acc);
		wait_pending(28, 100);
		egress_rd = '1;
		wait_pending(0, 1000);
		send_packet(3, 1, 7, $urandom, acc); // slice refilled by returned pointers
		wait_pending(0, 1000);

		test_name = "illegal_length";
		send_packet(2, 0, 0, $urandom, acc);
		step_cycles(40); // a stray cell would show up here
		send_packet(2, 3, 3, $urandom, acc);
		wait_pending(0, 500);

		$display("Regression passed");
		$finish;
	end

endmodule

// File: build.f
common/gsm_pkg.sv
hw/rr_arbiter.sv
hw/ptr_fifo.sv
hw/cell_buffer.sv
hw/ingress/hw_malloc.sv
hw/egress/egress_sched.sv
hw/gsm_tile.sv
verification/gsm_tile_asserts.sv
verification/tb_gsm_tile.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat build.f))

.PHONY: all run clean

all: obj_dir/Vtb_gsm_tile

obj_dir/Vtb_gsm_tile: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module tb_gsm_tile -o Vtb_gsm_tile

run: obj_dir/Vtb_gsm_tile
	./obj_dir/Vtb_gsm_tile

clean:
	rm -rf obj_dir
